//--- fir_filter.f
+incdir+testbench
common/fir_data_pkg.sv
common/fir_ctrl_pkg.sv
src/fir_sp_ram.sv
sequencer/fir_sequencer.sv
datapath/fir_mac.sv
src/fir_top.sv
testbench/fir_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the FIR testbench with Verilator, run it and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module fir_tb -Mdir obj_dir -o fir_sim -f fir_filter.f \
	&& ./obj_dir/fir_sim > sim.log 2>&1 \
	|| echo "Build or simulation stopped with an error"

cat sim.log 2>/dev/null
grep -qF '*** TEST PASSED ***' sim.log 2>/dev/null \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

//--- testbench/fir_tb_vectors.svh
/*
 * FIR testbench vectors
 * Entry type and the ordered table of coefficient loads and samples
 */
`ifndef FIR_TB_VECTORS_SVH
`define FIR_TB_VECTORS_SVH

typedef enum logic [1:0] {
	E_COEF,      // Load all 64 taps from a pattern
	E_SAMPLE     // Send count samples
} entry_kind_t;

typedef enum logic [1:0] {
	P_ZERO,
	P_CONST,     // Every tap gets value
	P_RAMP,      // Falls by 517 per tap through zero
	P_RAND       // Drawn at run time and scaled down
} coef_pat_t;

typedef enum logic [1:0] {
	X_MODEL,     // Golden model only
	X_FIXED,     // Golden model and the fixed exp_dout and exp_full
	X_IMPULSE    // Golden model and c[k] * 16384 with k counted from the impulse
} chk_mode_t;

typedef struct packed {
	entry_kind_t kind;
	coef_pat_t   pat;
	int          value;      // Coefficient base or sample
	bit          rand_val;   // Sample drawn at run time
	int          count;      // Samples sent by this entry
	chk_mode_t   chk;
	int          exp_dout;
	longint      exp_full;
	bit          busy;       // Poke valid_in and cload mid-frame
} entry_t;

localparam int NUM_ENTRIES = 15;

// kind      pat      value   rnd   cnt  chk        exp_dout  exp_full             busy
localparam entry_t VEC_TABLE [NUM_ENTRIES] = '{
	'{E_COEF,   P_ZERO,  0,      1'b0, 1,  X_MODEL,   0,      64'sd0,              1'b0},
	'{E_SAMPLE, P_ZERO,  4660,   1'b0, 1,  X_FIXED,   0,      64'sd0,              1'b0},
	'{E_SAMPLE, P_ZERO,  0,      1'b0, 63, X_MODEL,   0,      64'sd0,              1'b0},
	'{E_COEF,   P_RAMP,  16001,  1'b0, 1,  X_MODEL,   0,      64'sd0,              1'b0},
	'{E_SAMPLE, P_ZERO,  16384,  1'b0, 1,  X_IMPULSE, 0,      64'sd0,              1'b0},
	'{E_SAMPLE, P_ZERO,  0,      1'b0, 40, X_IMPULSE, 0,      64'sd0,              1'b0},
	'{E_SAMPLE, P_ZERO,  0,      1'b0, 23, X_IMPULSE, 0,      64'sd0,              1'b1},
	'{E_COEF,   P_RAND,  0,      1'b0, 1,  X_MODEL,   0,      64'sd0,              1'b0},
	'{E_SAMPLE, P_ZERO,  0,      1'b1, 12, X_MODEL,   0,      64'sd0,              1'b0},
	'{E_SAMPLE, P_ZERO,  0,      1'b1, 8,  X_MODEL,   0,      64'sd0,              1'b1},
	'{E_COEF,   P_CONST, 32767,  1'b0, 1,  X_MODEL,   0,      64'sd0,              1'b0},
	'{E_SAMPLE, P_ZERO,  32767,  1'b0, 63, X_MODEL,   0,      64'sd0,              1'b0},
	'{E_SAMPLE, P_ZERO,  32767,  1'b0, 1,  X_FIXED,   32767,  64'sd68715282496,    1'b0},
	'{E_COEF,   P_CONST, -32767, 1'b0, 1,  X_MODEL,   0,      64'sd0,              1'b0},
	'{E_SAMPLE, P_ZERO,  32767,  1'b0, 1,  X_FIXED,   -32768, -64'sd68715282496,   1'b0}
};

`endif

//--- testbench/fir_tb.sv
/*
 * FIR filter testbench
 * Table-driven coefficient loads and samples checked against a golden model
 */
module fir_tb
	import fir_data_pkg::*;
	import fir_ctrl_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	`include "fir_tb_vectors.svh"

	logic      alu_clk;
	logic      clk_fast;     // Async reset, active low
	sample_t   din;
	logic      valid_in;
	coef_t     cin;
	tap_addr_t caddr;
	logic      cload;
	logic      ready;
	sample_t   dout;
	acc_t      dout_full;
	logic      valid;

	int coef_model [NUM_TAPS];   // Golden coefficient table
	int hist_model [NUM_TAPS];   // Newest sample at index 0
	int error_count;
	int result_count;
	int cycle_count;
	int cycle_limit;             // Zero until the table is sized

	fir_top u_fir_top (
		.alu_clk   (alu_clk),
		.clk_fast  (clk_fast),
		.din       (din),
		.valid_in  (valid_in),
		.cin       (cin),
		.caddr     (caddr),
		.cload     (cload),
		.ready     (ready),
		.dout      (dout),
		.dout_full (dout_full),
		.valid     (valid)
	);

	initial begin
		alu_clk = 1'b0;
		forever #2 alu_clk = ~alu_clk;   // 4 ns period
	end

	// Inputs change and outputs are read 1 ns after the edge
	task automatic step_cycle();
		@(posedge alu_clk);
		#1;
	endtask

	task automatic report_error(input string msg);
		error_count++;
		$display("CHECK FAILED at %0t: %s", $time, msg);
	endtask

	task automatic report_problem(input string msg);
		error_count++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	function automatic int coef_value(input coef_pat_t pat, input int base, input int k);
		case (pat)
			P_CONST: return base;
			P_RAMP:  return base - 517 * k;
			P_RAND:  return int'(coef_t'($urandom)) >>> 4;   // About +-2048
			default: return 0;
		endcase
	endfunction

	// Shift the history by one sample
	function automatic void model_push(input int v);
		int k;
		for (k = NUM_TAPS - 1; k > 0; k--) begin
			hist_model[k] = hist_model[k - 1];
		end
		hist_model[0] = v;
	endfunction

	// y(n) = sum of c[k] * x(n-k)
	function automatic longint model_sum();
		longint y;
		int     k;
		y = 0;
		for (k = 0; k < NUM_TAPS; k++) begin
			y += longint'(coef_model[k]) * longint'(hist_model[k]);
		end
		return y;
	endfunction

	// Q15 scale by floor shift, then clamp to 16 bits
	function automatic int scale_clamp(input longint y);
		longint s;
		s = y >>> 15;
		if (s > 32767) return 32767;
		if (s < -32768) return -32768;
		return int'(s);
	endfunction

	// Ready must come up exactly CLEAR_LEN cycles after reset release
	task automatic wait_clear();
		int n;
		n = 0;
		while (!ready && n < CLEAR_LEN + 20) begin
			if (valid) report_error("valid high during the clear phase");
			step_cycle();
			n++;
		end
		if (n != CLEAR_LEN) begin
			report_error($sformatf("ready rose after %0d cycles, expected %0d", n, CLEAR_LEN));
		end
	endtask

	task automatic load_coefs(input coef_pat_t pat, input int base);
		int k;
		int c;
		while (!ready) step_cycle();
		for (k = 0; k < NUM_TAPS; k++) begin
			c             = coef_value(pat, base, k);
			coef_model[k] = c;
			cload         = 1'b1;
			caddr         = tap_addr_t'(k);
			cin           = coef_t'(c);
			step_cycle();                     // One write per IDLE cycle
		end
		cload = 1'b0;
	endtask

	// One accepted sample, then wait for its strobe and grab the result
	task automatic send_sample(input int v, input bit busy, output int got_d,
			output longint got_f);
		int n;
		bit early;
		n     = 0;
		early = 1'b0;
		while (!ready) step_cycle();          // Watchdog bounds this wait
		din      = sample_t'(v);
		valid_in = 1'b1;
		step_cycle();                         // Accepting edge E0
		valid_in = 1'b0;
		while (!valid && n <= RESULT_LATENCY + 8) begin
			if (ready) early = 1'b1;
			// Junk while busy, must leave no trace
			if (busy && n >= 3 && n < 12) begin
				valid_in = 1'b1;
				cload    = 1'b1;
				din      = sample_t'($urandom);
				caddr    = tap_addr_t'($urandom);
				cin      = coef_t'($urandom);
			end else begin
				valid_in = 1'b0;
				cload    = 1'b0;
			end
			step_cycle();
			n++;
		end
		got_d = int'(dout);
		got_f = longint'(dout_full);
		if (early) report_error("ready high before the result was done");
		if (!valid) begin
			report_problem("valid never rose after the sample was accepted");
		end else begin
			if (n != RESULT_LATENCY) begin
				report_error($sformatf("valid after %0d edges, expected %0d", n, RESULT_LATENCY));
			end
			if (!ready) report_error("ready low at the valid edge");
		end
		step_cycle();
		if (valid) report_error("valid held longer than one cycle");
	endtask

	initial begin
		entry_t ent;
		int     i;
		int     r;
		int     v;
		int     ops;
		int     imp_k;
		int     exp_d;
		longint exp_f;
		int     got_d;
		longint got_f;

		void'($urandom(50158));               // Single seed for the run
		error_count  = 0;
		result_count = 0;
		imp_k        = 0;
		clk_fast     = 1'b0;
		din          = '0;
		valid_in     = 1'b0;
		cin          = '0;
		caddr        = '0;
		cload        = 1'b0;

		ops = 0;
		for (i = 0; i < NUM_ENTRIES; i++) begin
			ops += VEC_TABLE[i].count;
		end
		cycle_limit = CLEAR_LEN + 80 * ops + 200;

		repeat (4) @(posedge alu_clk);
		#1;
		clk_fast = 1'b1;
		wait_clear();

		for (i = 0; i < NUM_ENTRIES; i++) begin
			ent = VEC_TABLE[i];
			if (ent.kind == E_COEF) begin
				load_coefs(ent.pat, ent.value);
			end else begin
				for (r = 0; r < ent.count; r++) begin
					v = ent.rand_val ? int'(sample_t'($urandom)) : ent.value;
					model_push(v);
					exp_f = model_sum();
					exp_d = scale_clamp(exp_f);
					if (ent.chk == X_IMPULSE) begin
						imp_k = (v != 0) ? 0 : imp_k + 1;   // Taps since the impulse
					end
					send_sample(v, ent.busy, got_d, got_f);
					result_count++;
					if (got_d != exp_d || got_f != exp_f) begin
						report_error($sformatf("entry %0d sample %0d gives %0d / %0d, model %0d / %0d",
							i, r, got_d, got_f, exp_d, exp_f));
					end
					if (ent.chk == X_FIXED && (got_d != ent.exp_dout || got_f != ent.exp_full)) begin
						report_error($sformatf("entry %0d gives %0d / %0d, fixed %0d / %0d",
							i, got_d, got_f, ent.exp_dout, ent.exp_full));
					end
					// Impulse of 0x4000 reads back each tap
					if (ent.chk == X_IMPULSE && imp_k < NUM_TAPS &&
						(got_f != longint'(coef_model[imp_k]) * 64'sd16384 ||
						got_d != (coef_model[imp_k] >>> 1))) begin
						report_error($sformatf("impulse tap %0d gives %0d / %0d for c = %0d",
							imp_k, got_d, got_f, coef_model[imp_k]));
					end
				end
			end
		end

		$display("Summary: %0d results checked, %0d errors", result_count, error_count);
		if (error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// Watchdog on total cycles
	initial begin
		cycle_count = 0;
		while (cycle_limit == 0 || cycle_count < cycle_limit) begin
			@(posedge alu_clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the run did not finish", cycle_count);
		$display("Summary: %0d results checked, %0d errors", result_count, error_count + 1);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- src/fir_top.sv
/*
 * FIR filter top
 * 64-tap direct-form engine around one sequencer, two memories and a MAC
 */
module fir_top
	import fir_data_pkg::*;
(
	input  logic      alu_clk,
	input  logic      clk_fast,    // Async reset, active low
	input  sample_t   din,
	input  logic      valid_in,
	input  coef_t     cin,
	input  tap_addr_t caddr,
	input  logic      cload,
	output logic      ready,
	output sample_t   dout,        // Scaled and clamped
	output acc_t      dout_full,   // Raw accumulator
	output logic      valid
);

	logic      sample_we;
	tap_addr_t sample_addr;
	sample_t   sample_wdata;
	sample_t   sample_rdata;

	logic      coef_we;
	tap_addr_t coef_addr;
	coef_t     coef_rdata;

	logic      tap_valid;
	logic      tap_first;

	fir_sequencer u_sequencer (
		.alu_clk      (alu_clk),
		.clk_fast     (clk_fast),
		.din          (din),
		.valid_in     (valid_in),
		.cload        (cload),
		.caddr        (caddr),
		.ready        (ready),
		.valid        (valid),
		.sample_we    (sample_we),
		.sample_addr  (sample_addr),
		.sample_wdata (sample_wdata),
		.coef_we      (coef_we),
		.coef_addr    (coef_addr),
		.tap_valid    (tap_valid),
		.tap_first    (tap_first)
	);

	// Circular history
	fir_sp_ram #(.word_t(sample_t)) u_sample_ram (
		.alu_clk (alu_clk),
		.we      (sample_we),
		.addr    (sample_addr),
		.wdata   (sample_wdata),
		.rdata   (sample_rdata)
	);

	// Coefficient table, written straight from cin
	fir_sp_ram #(.word_t(coef_t)) u_coef_ram (
		.alu_clk (alu_clk),
		.we      (coef_we),
		.addr    (coef_addr),
		.wdata   (cin),
		.rdata   (coef_rdata)
	);

	fir_mac u_mac (
		.alu_clk   (alu_clk),
		.clk_fast  (clk_fast),
		.sample    (sample_rdata),
		.coef      (coef_rdata),
		.tap_valid (tap_valid),
		.tap_first (tap_first),
		.dout      (dout),
		.dout_full (dout_full)
	);

endmodule

//--- datapath/fir_mac.sv
/*
 * FIR multiply-accumulate
 * Registered product, 40-bit accumulator, Q15 scaling with saturation
 */
module fir_mac
	import fir_data_pkg::*;
	import fir_ctrl_pkg::*;
(
	input  logic    alu_clk,
	input  logic    clk_fast,    // Async reset, active low
	input  sample_t sample,      // History RAM read data
	input  coef_t   coef,        // Coefficient RAM read data
	input  logic    tap_valid,   // Aligned with the issued address
	input  logic    tap_first,
	output sample_t dout,
	output acc_t    dout_full
);

	// Control pipe
	// bit 0 lines up with RAM data, top bit with the product register
	logic [MAC_PIPE_DEPTH-2:0] vld_pipe;
	logic [MAC_PIPE_DEPTH-2:0] first_pipe;

	product_t product_r;
	acc_t     acc;
	acc_t     acc_shr;           // Arithmetic shift of the sum

	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			vld_pipe   <= '0;
			first_pipe <= '0;
		end else begin
			vld_pipe   <= {vld_pipe[MAC_PIPE_DEPTH-3:0], tap_valid};
			first_pipe <= {first_pipe[MAC_PIPE_DEPTH-3:0], tap_first};
		end
	end

	// 16x16 signed, full 32-bit result
	always_ff @(posedge alu_clk) begin
		if (vld_pipe[0]) begin
			product_r <= sample * coef;
		end
	end

	// First tap loads, the rest add
	// Held between frames so dout stays until the next sum starts
	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			acc <= '0;
		end else if (vld_pipe[MAC_PIPE_DEPTH-2]) begin
			if (first_pipe[MAC_PIPE_DEPTH-2]) begin
				acc <= acc_t'(product_r);          // Sign extended
			end else begin
				acc <= acc + acc_t'(product_r);
			end
		end
	end

	assign dout_full = acc;
	assign acc_shr   = acc >>> OUT_SHIFT;   // Floor, not rounded

	// Clamp to 16-bit range
	always_comb begin
		if (acc_shr > acc_t'(OUT_MAX)) begin
			dout = OUT_MAX;
		end else if (acc_shr < acc_t'(OUT_MIN)) begin
			dout = OUT_MIN;
		end else begin
			dout = sample_t'(acc_shr);
		end
	end

	// Every frame is a full unbroken 64-tap burst
	a_tap_burst: assert property (@(posedge alu_clk) disable iff (!clk_fast)
		tap_first |=> (tap_valid && !tap_first) [*(NUM_TAPS - 1)])
		else $error("tap burst broken before 64 taps");

endmodule

//--- sequencer/fir_sequencer.sv
/*
 * FIR frame sequencer
 * Clears history, latches samples, walks 64 taps and flags each result
 */
module fir_sequencer
	import fir_data_pkg::*;
	import fir_ctrl_pkg::*;
(
	input  logic      alu_clk,
	input  logic      clk_fast,       // Async reset, active low
	input  sample_t   din,
	input  logic      valid_in,
	input  logic      cload,
	input  tap_addr_t caddr,
	output logic      ready,
	output logic      valid,          // One-cycle result strobe
	output logic      sample_we,
	output tap_addr_t sample_addr,
	output sample_t   sample_wdata,
	output logic      coef_we,
	output tap_addr_t coef_addr,
	output logic      tap_valid,      // Address pair on the memories is a tap
	output logic      tap_first       // Tap 0 restarts the sum
);

	seq_state_t state;
	seq_state_t state_nxt;
	tap_addr_t  cnt;        // Shared phase counter
	tap_addr_t  wr_ptr;     // Slot of the newest sample
	sample_t    sample_r;   // Held from accept to LATCH
	logic       accept;
	logic       cnt_last;

	assign accept = (state == IDLE) && valid_in;

	// End of the current phase
	always_comb begin
		case (state)
			CLEAR:   cnt_last = (cnt == TAP_ADDR_W'(CLEAR_LEN - 1));
			ISSUE:   cnt_last = (cnt == TAP_ADDR_W'(NUM_TAPS - 1));
			DRAIN:   cnt_last = (cnt == TAP_ADDR_W'(DRAIN_LEN - 1));
			default: cnt_last = 1'b1;                     // Single-cycle phases
		endcase
	end

	always_comb begin
		state_nxt = state;
		case (state)
			CLEAR:   if (cnt_last) state_nxt = IDLE;
			IDLE:    if (accept) state_nxt = LATCH;
			LATCH:   state_nxt = ISSUE;
			ISSUE:   if (cnt_last) state_nxt = DRAIN;
			DRAIN:   if (cnt_last) state_nxt = DONE;
			DONE:    state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			state  <= CLEAR;
			cnt    <= '0;
			wr_ptr <= '0;
			valid  <= 1'b0;
		end else begin
			state <= state_nxt;
			valid <= (state == DONE);          // Rises as ready returns
			// Counter restarts on every phase change
			if (state_nxt != state) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
			if (state == DONE) begin
				wr_ptr <= wr_ptr + 1'b1;       // Next free slot
			end
		end
	end

	always_ff @(posedge alu_clk) begin
		if (accept) begin
			sample_r <= din;
		end
	end

	assign ready = (state == IDLE);

	// History port
	// cnt is zero in LATCH so the same subtract gives wr_ptr there
	assign sample_we    = (state == CLEAR) || (state == LATCH);
	assign sample_wdata = (state == LATCH) ? sample_r : '0;
	assign sample_addr  = (state == CLEAR) ? cnt : tap_addr_t'(wr_ptr - cnt);

	// Host owns the coefficient port only in IDLE
	assign coef_we   = cload && (state == IDLE);
	assign coef_addr = (state == IDLE) ? caddr : cnt;

	assign tap_valid = (state == ISSUE);
	assign tap_first = tap_valid && (cnt == '0);

	// Strobe must drop after one cycle
	a_valid_pulse: assert property (@(posedge alu_clk) disable iff (!clk_fast)
		valid |=> !valid)
		else $error("valid held for more than one cycle");

	// History is never written while taps or their read data are in flight
	a_we_vs_tap: assert property (@(posedge alu_clk) disable iff (!clk_fast)
		sample_we |-> !tap_valid && !$past(tap_valid))
		else $error("sample write during tap issue");

	// Coefficients stay frozen from an accepted sample to its result
	a_coef_idle: assert property (@(posedge alu_clk) disable iff (!clk_fast)
		accept |=> !coef_we [*RESULT_LATENCY])
		else $error("coefficient write during a frame");

	// valid is set at edge E68 and seen at the next sampling edge
	a_latency: assert property (@(posedge alu_clk) disable iff (!clk_fast)
		accept |-> ##(RESULT_LATENCY + 1) valid)
		else $error("result strobe off the fixed latency");

endmodule

//--- src/fir_sp_ram.sv
/*
 * Single-port 64-word memory
 * Synchronous write, registered read, payload set by word_t
 */
module fir_sp_ram
	import fir_data_pkg::*;
#(
	parameter type word_t = sample_t
) (
	input  logic      alu_clk,
	input  logic      we,
	input  tap_addr_t addr,
	input  word_t     wdata,
	output word_t     rdata    // One edge after addr
);

	word_t mem [NUM_TAPS];     // Contents set by CLEAR or coefficient loads

	// Read returns old data on a write cycle
	always_ff @(posedge alu_clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

//--- common/fir_ctrl_pkg.sv
/*
 * FIR control definitions
 * Sequencer states, phase lengths and result latency
 */
package fir_ctrl_pkg;

	// Frame states
	typedef enum logic [2:0] {
		CLEAR = 3'd0,   // Zero the history after reset
		IDLE  = 3'd1,   // Ready, coefficient writes allowed
		LATCH = 3'd2,   // Write held sample into history
		ISSUE = 3'd3,   // One tap per cycle
		DRAIN = 3'd4,   // Wait for MAC pipe
		DONE  = 3'd5    // Last cycle before valid
	} seq_state_t;

	localparam int CLEAR_LEN      = 64;                 // One write per history slot
	localparam int MAC_PIPE_DEPTH = 3;                  // Address, RAM data, product
	localparam int DRAIN_LEN      = MAC_PIPE_DEPTH - 1;

	// Accept edge to valid edge
	// 1 latch + 64 issue + 2 drain + 1 done
	localparam int RESULT_LATENCY = 68;

endpackage

//--- common/fir_data_pkg.sv
/*
 * FIR data definitions
 * Sample, coefficient and accumulator types, tap count and output scaling
 */
package fir_data_pkg;

	localparam int NUM_TAPS   = 64;
	localparam int TAP_ADDR_W = $clog2(NUM_TAPS);   // 6 bits, wraps mod 64

	localparam int SAMPLE_W  = 16;
	localparam int COEF_W    = 16;
	localparam int PRODUCT_W = SAMPLE_W + COEF_W;
	localparam int ACC_W     = 40;                  // 8 guard bits over a product

	// Signed fixed point throughout
	typedef logic signed [SAMPLE_W-1:0]  sample_t;
	typedef logic signed [COEF_W-1:0]    coef_t;
	typedef logic signed [PRODUCT_W-1:0] product_t;
	typedef logic signed [ACC_W-1:0]     acc_t;

	// History and coefficient address
	typedef logic [TAP_ADDR_W-1:0] tap_addr_t;

	// Q15 coefficients, so the sum is scaled back by 15
	localparam int OUT_SHIFT = 15;

	// dout clamp limits
	localparam sample_t OUT_MAX = 16'sh7FFF;
	localparam sample_t OUT_MIN = 16'sh8000;

endpackage
